// File: test/fp_noncomp_cases.txt
# op rm mod operand_a operand_b exp_result exp_status exp_class_mask (all hex)
# op 0 sgnj, 1 minmax, 2 cmp, 3 classify; rm picks the sub-operation
0 0 0 3F800000 C0000000 BF800000 00 200
0 1 0 3F800000 C0000000 3F800000 00 200
0 2 0 BF800000 C0000000 3F800000 00 200
0 0 0 80000000 40000000 00000000 00 200
0 1 0 7FC00000 40000000 FFC00000 00 200
0 2 0 7F800001 C0000000 FF800001 00 200
1 0 0 3F800000 C0000000 C0000000 00 200
1 1 0 3F800000 C0000000 3F800000 00 200
1 0 0 00000000 80000000 80000000 00 200
1 1 0 00000000 80000000 00000000 00 200
1 0 0 7FC00000 40000000 40000000 00 200
1 1 0 7FC00000 7FC00000 7FC00000 00 200
1 1 0 FFC00000 7F800001 7FC00000 10 200
1 0 0 7F800001 3F800000 3F800000 10 200
2 0 0 3F800000 40000000 00000001 00 200
2 1 0 40000000 40000000 00000000 00 200
2 1 1 40000000 40000000 00000001 00 200
2 1 0 C0000000 BF800000 00000001 00 200
2 2 0 00000000 80000000 00000001 00 200
2 0 0 80000000 00000000 00000001 00 200
2 2 1 7FC00000 3F800000 00000001 00 200
2 2 0 7FC00000 3F800000 00000000 00 200
2 0 0 3F800000 7FC00000 00000000 10 200
2 1 1 7FC00000 3F800000 00000000 10 200
2 2 1 7F800001 3F800000 00000000 10 200
2 1 1 3F800000 7F800001 00000000 10 200
3 0 0 FF800000 00000000 00000000 00 001
3 0 0 BF800000 00000000 00000000 00 002
3 0 0 80000001 00000000 00000000 00 004
3 0 0 80000000 00000000 00000000 00 008
3 0 0 00000000 00000000 00000000 00 010
3 0 0 00000001 00000000 00000000 00 020
3 0 0 3F800000 00000000 00000000 00 040
3 0 0 7F800000 00000000 00000000 00 080
3 0 0 7F800001 00000000 00000000 00 100
3 0 0 7FC00000 00000000 00000000 00 200

// File: fp_noncomp.f
design/fp_noncomp_pkg.sv
design/fp_pipe_reg.sv
design/fp_classify.sv
design/fp_op_decode.sv
design/fp_noncomp_exec.sv
design/fp_noncomp.sv
test/tb_fp_noncomp.sv

// File: test/tb_fp_noncomp.sv
`default_nettype none

module tb_fp_noncomp;

  timeunit 1ns;
  timeprecision 1ps;

  import fp_noncomp_pkg::*;

  localparam int         MAX_CASES  = 64;
  localparam int         WAIT_LIMIT = 200;
  localparam logic [7:0] LFSR_SEED  = 8'd94;

  // DUT connections
  logic          clk;
  logic          rst_n;
  fp_word_t      operands_a;
  fp_word_t      operands_b;
  fp_op_e        op;
  fp_rm_e        rm;
  logic          op_mod;
  logic          in_valid;
  logic          in_ready;
  logic          flush;
  fp_word_t      result;
  fp_status_t    status;
  fp_classmask_e class_mask;
  logic          is_class;
  logic          out_valid;
  logic          out_ready;
  logic          busy;

  // Case table loaded from the data file
  fp_op_e        case_op     [MAX_CASES];
  fp_rm_e        case_rm     [MAX_CASES];
  logic          case_mod    [MAX_CASES];
  fp_word_t      case_a      [MAX_CASES];
  fp_word_t      case_b      [MAX_CASES];
  fp_word_t      case_result [MAX_CASES];
  fp_status_t    case_status [MAX_CASES];
  fp_classmask_e case_class  [MAX_CASES];
  int            num_cases;

  // Indices of accepted cases in order of acceptance
  int            inflight [$];
  int            err_count;
  int            fail_count;
  logic [7:0]    lfsr_state;

  // 40 ns period
  always #20 clk = ~clk;

  fp_noncomp dut_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .operands_a_i (operands_a),
    .operands_b_i (operands_b),
    .op_i         (op),
    .rm_i         (rm),
    .op_mod_i     (op_mod),
    .in_valid_i   (in_valid),
    .in_ready_o   (in_ready),
    .flush_i      (flush),
    .result_o     (result),
    .status_o     (status),
    .class_mask_o (class_mask),
    .is_class_o   (is_class),
    .out_valid_o  (out_valid),
    .out_ready_i  (out_ready),
    .busy_o       (busy)
  );

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------
  // Fibonacci LFSR with taps for x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] state);
    logic feedback;
    feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
    return {state[6:0], feedback};
  endfunction

  task automatic check_result(input fp_word_t got, input fp_word_t exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s result %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_status(input fp_status_t got, input fp_status_t exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s status %b, expected %b", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_class(input fp_classmask_e got, input fp_classmask_e exp,
                             input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s class mask %b, expected %b", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      err_count++;
    end
  endtask

  // Lines that do not parse as eight hex fields are comments
  task automatic load_cases();
    int                fd;
    int                code;
    logic [8*160-1:0]  line;
    logic [3:0]        f_op;
    logic [3:0]        f_rm;
    logic [3:0]        f_mod;
    logic [31:0]       f_a;
    logic [31:0]       f_b;
    logic [31:0]       f_res;
    logic [7:0]        f_st;
    logic [11:0]       f_cls;
    fd = $fopen("test/fp_noncomp_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file test/fp_noncomp_cases.txt");
      fail_count++;
    end else begin
      while (!$feof(fd) && num_cases < MAX_CASES) begin
        line = '0;
        code = $fgets(line, fd);
        if (code > 0 && $sscanf(line, "%h %h %h %h %h %h %h %h",
                                f_op, f_rm, f_mod, f_a, f_b, f_res, f_st, f_cls) == 8) begin
          case_op[num_cases]     = fp_op_e'(f_op[1:0]);
          case_rm[num_cases]     = fp_rm_e'(f_rm[2:0]);
          case_mod[num_cases]    = f_mod[0];
          case_a[num_cases]      = f_a;
          case_b[num_cases]      = f_b;
          case_result[num_cases] = f_res;
          case_status[num_cases] = f_st[4:0];
          case_class[num_cases]  = fp_classmask_e'(f_cls[9:0]);
          num_cases++;
        end
      end
      $fclose(fd);
      if (num_cases == 0) begin
        $display("The case file holds no usable cases");
        fail_count++;
      end
    end
  endtask

  // ------------------------------------------------
  // Driver
  // ------------------------------------------------
  // Sends one case per transfer and holds it until in_ready is seen at a rising edge
  task automatic drive_cases();
    int   idx;
    int   waited;
    logic accepted;
    for (idx = 0; idx < num_cases; idx++) begin
      @(negedge clk);
      operands_a = case_a[idx];
      operands_b = case_b[idx];
      op         = case_op[idx];
      rm         = case_rm[idx];
      op_mod     = case_mod[idx];
      in_valid   = 1'b1;
      accepted   = 1'b0;
      waited     = 0;
      while (!accepted && waited < WAIT_LIMIT) begin
        @(posedge clk);
        if (in_ready) begin
          accepted = 1'b1;
          inflight.push_back(idx);
        end else begin
          waited++;
        end
      end
      if (!accepted) begin
        $display("Timeout: the DUT never accepted case %0d", idx);
        fail_count++;
        break;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // ------------------------------------------------
  // Monitor with random back-pressure
  // ------------------------------------------------
  task automatic collect_outputs();
    int            received;
    int            idle;
    int            exp_idx;
    logic          held;
    fp_word_t      held_result;
    fp_status_t    held_status;
    fp_classmask_e held_class;
    logic          held_is_class;
    string         tag;
    received = 0;
    idle     = 0;
    held     = 1'b0;
    while (received < num_cases && idle < WAIT_LIMIT) begin
      @(negedge clk);
      // One LFSR step per ready bit
      lfsr_state = lfsr_step(lfsr_state);
      out_ready  = lfsr_state[0];
      @(posedge clk);
      // Item stalled last cycle must still be there unchanged
      if (held) begin
        check_flag(out_valid, 1'b1, "out_valid under stall");
        check_result(result, held_result, "stalled item");
        check_status(status, held_status, "stalled item");
        check_class(class_mask, held_class, "stalled item");
        check_flag(is_class, held_is_class, "stalled item is_class");
      end
      held          = out_valid && !out_ready;
      held_result   = result;
      held_status   = status;
      held_class    = class_mask;
      held_is_class = is_class;
      if (out_valid && out_ready) begin
        idle = 0;
        if (inflight.size() == 0) begin
          $display("The DUT produced an output with no case in flight");
          fail_count++;
        end else begin
          exp_idx = inflight.pop_front();
          tag     = $sformatf("case %0d", exp_idx);
          check_result(result, case_result[exp_idx], tag);
          check_status(status, case_status[exp_idx], tag);
          check_class(class_mask, case_class[exp_idx], tag);
          // Marker set for classify only
          check_flag(is_class, case_op[exp_idx] == OP_CLASSIFY, {tag, " is_class"});
        end
        received++;
      end else begin
        idle++;
      end
    end
    if (received < num_cases) begin
      $display("Timeout: only %0d of %0d results came out", received, num_cases);
      fail_count++;
    end
    @(negedge clk);
    out_ready = 1'b1;
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------
  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    operands_a = '0;
    operands_b = '0;
    op         = OP_SGNJ;
    rm         = RM_RNE;
    op_mod     = 1'b0;
    in_valid   = 1'b0;
    flush      = 1'b0;
    out_ready  = 1'b0;
    err_count  = 0;
    fail_count = 0;
    num_cases  = 0;
    lfsr_state = LFSR_SEED;
    load_cases();
    // Three cycles in reset
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_flag(out_valid, 1'b0, "out_valid after reset");
    check_flag(busy, 1'b0, "busy after reset");
    check_flag(in_ready, 1'b1, "in_ready after reset");
    rst_n = 1'b1;
    if (num_cases > 0) begin
      fork
        drive_cases();
        collect_outputs();
      join
    end
    // Both stages empty right after the last result has left
    check_flag(busy, 1'b0, "busy after last output");
    $display("errors: %0d mismatches, %0d other failures", err_count, fail_count);
    if (err_count == 0 && fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/fp_noncomp.sv
`default_nettype none

module fp_noncomp (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Operation
  input  fp_noncomp_pkg::fp_word_t      operands_a_i,
  input  fp_noncomp_pkg::fp_word_t      operands_b_i,
  input  fp_noncomp_pkg::fp_op_e        op_i,
  input  fp_noncomp_pkg::fp_rm_e        rm_i,
  input  logic                          op_mod_i,
  // Input handshake
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  input  logic                          flush_i,
  // Result
  output fp_noncomp_pkg::fp_word_t      result_o,
  output fp_noncomp_pkg::fp_status_t    status_o,
  output fp_noncomp_pkg::fp_classmask_e class_mask_o,
  output logic                          is_class_o,
  // Output handshake
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  output logic                          busy_o
);

  import fp_noncomp_pkg::*;

  logic [PIPE_IN_BITS-1:0]  in_data;
  logic [PIPE_IN_BITS-1:0]  stage_data;
  logic                     stage_valid;
  logic                     stage_ready;
  fp_word_t                 stage_a;
  fp_word_t                 stage_b;
  fp_op_e                   stage_op;
  fp_rm_e                   stage_rm;
  logic                     stage_op_mod;
  fp_func_e                 func;
  fp_info_t                 info_a;
  fp_info_t                 info_b;
  logic                     a_smaller;
  logic                     equal;
  fp_word_t                 exec_result;
  fp_status_t               exec_status;
  fp_classmask_e            exec_class_mask;
  logic                     exec_is_class;
  logic [PIPE_OUT_BITS-1:0] exec_data;
  logic [PIPE_OUT_BITS-1:0] out_data;

  // ------------------------------------------------
  // Input stage
  // ------------------------------------------------
  assign in_data = {operands_a_i, operands_b_i, op_i, rm_i, op_mod_i};

  fp_pipe_reg #(
    .DataWidth (PIPE_IN_BITS)
  ) u_input_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (in_data),
    .valid_o (stage_valid),
    .ready_i (stage_ready),
    .data_o  (stage_data)
  );

  // Unpack, same order as packed above
  assign stage_a      = stage_data[PIPE_IN_BITS-1 -: FP_WIDTH];
  assign stage_b      = stage_data[PIPE_IN_BITS-FP_WIDTH-1 -: FP_WIDTH];
  assign stage_op     = fp_op_e'(stage_data[5:4]);
  assign stage_rm     = fp_rm_e'(stage_data[3:1]);
  assign stage_op_mod = stage_data[0];

  // ------------------------------------------------
  // Decode and execute, combinational
  // ------------------------------------------------
  fp_op_decode u_decode (
    .op_i        (stage_op),
    .rm_i        (stage_rm),
    .operand_a_i (stage_a),
    .operand_b_i (stage_b),
    .valid_i     (stage_valid),
    .func_o      (func),
    .info_a_o    (info_a),
    .info_b_o    (info_b),
    .a_smaller_o (a_smaller),
    .equal_o     (equal)
  );

  fp_noncomp_exec u_exec (
    .func_i       (func),
    .op_mod_i     (stage_op_mod),
    .operand_a_i  (stage_a),
    .operand_b_i  (stage_b),
    .info_a_i     (info_a),
    .info_b_i     (info_b),
    .a_smaller_i  (a_smaller),
    .equal_i      (equal),
    .result_o     (exec_result),
    .status_o     (exec_status),
    .class_mask_o (exec_class_mask),
    .is_class_o   (exec_is_class)
  );

  // ------------------------------------------------
  // Result stage
  // ------------------------------------------------
  assign exec_data = {exec_result, exec_status, exec_class_mask, exec_is_class};

  // Its ready feeds back into the input stage
  fp_pipe_reg #(
    .DataWidth (PIPE_OUT_BITS)
  ) u_result_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (stage_valid),
    .ready_o (stage_ready),
    .data_i  (exec_data),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (out_data)
  );

  assign result_o     = out_data[PIPE_OUT_BITS-1 -: FP_WIDTH];
  assign status_o     = out_data[15:11];
  assign class_mask_o = fp_classmask_e'(out_data[10:1]);
  assign is_class_o   = out_data[0];

  // Anything held in either stage
  assign busy_o = stage_valid | out_valid_o;

endmodule

`default_nettype wire

// File: design/fp_noncomp_exec.sv
`default_nettype none

module fp_noncomp_exec (
  input  fp_noncomp_pkg::fp_func_e      func_i,
  input  logic                          op_mod_i,
  input  fp_noncomp_pkg::fp_word_t      operand_a_i,
  input  fp_noncomp_pkg::fp_word_t      operand_b_i,
  input  fp_noncomp_pkg::fp_info_t      info_a_i,
  input  fp_noncomp_pkg::fp_info_t      info_b_i,
  input  logic                          a_smaller_i,
  input  logic                          equal_i,
  output fp_noncomp_pkg::fp_word_t      result_o,
  output fp_noncomp_pkg::fp_status_t    status_o,
  output fp_noncomp_pkg::fp_classmask_e class_mask_o,
  output logic                          is_class_o
);

  import fp_noncomp_pkg::*;

  logic          sign_a;
  logic          sign_b;
  logic          any_nan;
  logic          any_snan;
  logic          sgnj_sign;
  fp_word_t      sgnj_result;
  fp_word_t      minmax_result;
  logic          cmp_bit;
  logic          cmp_nv;
  fp_classmask_e class_mask;

  assign sign_a   = operand_a_i[FP_WIDTH-1];
  assign sign_b   = operand_b_i[FP_WIDTH-1];
  assign any_nan  = info_a_i.is_nan || info_b_i.is_nan;
  assign any_snan = info_a_i.is_snan || info_b_i.is_snan;

  // ------------------------------------------------
  // Sign injection
  // ------------------------------------------------
  always_comb begin
    case (func_i)
      FN_SGNJN: sgnj_sign = ~sign_b;
      FN_SGNJX: sgnj_sign = sign_a ^ sign_b;
      default:  sgnj_sign = sign_b;
    endcase
  end

  // Magnitude always from operand a
  assign sgnj_result = {sgnj_sign, operand_a_i[FP_WIDTH-2:0]};

  // ------------------------------------------------
  // Min / max
  // ------------------------------------------------
  always_comb begin
    if (info_a_i.is_nan && info_b_i.is_nan) begin
      minmax_result = CANON_QNAN;
    end else if (info_a_i.is_nan) begin
      // NaN loses against any number
      minmax_result = operand_b_i;
    end else if (info_b_i.is_nan) begin
      minmax_result = operand_a_i;
    end else if (func_i == FN_MAX) begin
      minmax_result = a_smaller_i ? operand_b_i : operand_a_i;
    end else begin
      minmax_result = a_smaller_i ? operand_a_i : operand_b_i;
    end
  end

  // ------------------------------------------------
  // Comparisons
  // ------------------------------------------------
  always_comb begin
    cmp_bit = 1'b0;
    cmp_nv  = 1'b0;
    if (any_snan) begin
      // Invalid for every compare, result stays false
      cmp_nv = 1'b1;
    end else begin
      case (func_i)
        FN_LE: begin
          if (any_nan) cmp_nv = 1'b1;
          else         cmp_bit = (a_smaller_i | equal_i) ^ op_mod_i;
        end
        FN_LT: begin
          if (any_nan) cmp_nv = 1'b1;
          else         cmp_bit = (a_smaller_i & ~equal_i) ^ op_mod_i;
        end
        FN_EQ: begin
          // Quiet compare, NaN is never equal
          if (any_nan) cmp_bit = op_mod_i;
          else         cmp_bit = equal_i ^ op_mod_i;
        end
        default: cmp_bit = 1'b0;
      endcase
    end
  end

  // ------------------------------------------------
  // Classification of operand a
  // ------------------------------------------------
  always_comb begin
    if (info_a_i.is_normal)         class_mask = sign_a ? NEGNORM : POSNORM;
    else if (info_a_i.is_subnormal) class_mask = sign_a ? NEGSUBNORM : POSSUBNORM;
    else if (info_a_i.is_zero)      class_mask = sign_a ? NEGZERO : POSZERO;
    else if (info_a_i.is_inf)       class_mask = sign_a ? NEGINF : POSINF;
    else if (info_a_i.is_snan)      class_mask = SNAN;
    else                            class_mask = QNAN;
  end

  // ------------------------------------------------
  // Result select
  // ------------------------------------------------
  always_comb begin
    result_o     = '0;
    status_o     = '0;
    class_mask_o = QNAN;
    is_class_o   = 1'b0;
    case (func_i)
      // No flags from sign injection
      FN_SGNJ, FN_SGNJN, FN_SGNJX: begin
        result_o = sgnj_result;
      end
      FN_MIN, FN_MAX: begin
        result_o         = minmax_result;
        // Quiet NaNs pass silently
        status_o[NV_BIT] = any_snan;
      end
      FN_LE, FN_LT, FN_EQ: begin
        result_o         = {{(FP_WIDTH-1){1'b0}}, cmp_bit};
        status_o[NV_BIT] = cmp_nv;
      end
      FN_CLASS: begin
        // Answer lives on the mask port
        class_mask_o = class_mask;
        is_class_o   = 1'b1;
      end
      default: begin
        result_o         = CANON_QNAN;
        status_o[NV_BIT] = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/fp_op_decode.sv
`default_nettype none

module fp_op_decode (
  input  fp_noncomp_pkg::fp_op_e   op_i,
  input  fp_noncomp_pkg::fp_rm_e   rm_i,
  input  fp_noncomp_pkg::fp_word_t operand_a_i,
  input  fp_noncomp_pkg::fp_word_t operand_b_i,
  input  logic                     valid_i,
  output fp_noncomp_pkg::fp_func_e func_o,
  output fp_noncomp_pkg::fp_info_t info_a_o,
  output fp_noncomp_pkg::fp_info_t info_b_o,
  output logic                     a_smaller_o,
  output logic                     equal_o
);

  import fp_noncomp_pkg::*;

  logic sign_a;
  logic sign_b;

  // ------------------------------------------------
  // Function code
  // ------------------------------------------------
  always_comb begin
    func_o = FN_ILLEGAL;
    case (op_i)
      OP_SGNJ: begin
        case (rm_i)
          RM_RNE:  func_o = FN_SGNJ;
          RM_RTZ:  func_o = FN_SGNJN;
          RM_RDN:  func_o = FN_SGNJX;
          default: func_o = FN_ILLEGAL;
        endcase
      end
      OP_MINMAX: begin
        case (rm_i)
          RM_RNE:  func_o = FN_MIN;
          RM_RTZ:  func_o = FN_MAX;
          default: func_o = FN_ILLEGAL;
        endcase
      end
      OP_CMP: begin
        case (rm_i)
          RM_RNE:  func_o = FN_LE;
          RM_RTZ:  func_o = FN_LT;
          RM_RDN:  func_o = FN_EQ;
          default: func_o = FN_ILLEGAL;
        endcase
      end
      // Mode field is don't-care
      OP_CLASSIFY: func_o = FN_CLASS;
      default:     func_o = FN_ILLEGAL;
    endcase
  end

  // ------------------------------------------------
  // Operand classes
  // ------------------------------------------------
  fp_classify u_classify_a (
    .operand_i (operand_a_i),
    .info_o    (info_a_o)
  );

  fp_classify u_classify_b (
    .operand_i (operand_b_i),
    .info_o    (info_b_o)
  );

  // ------------------------------------------------
  // Ordering primitives
  // ------------------------------------------------
  assign sign_a = operand_a_i[FP_WIDTH-1];
  assign sign_b = operand_b_i[FP_WIDTH-1];

  // Sign-magnitude order, unsigned compare flips once a sign is set
  assign a_smaller_o = (operand_a_i < operand_b_i) ^ (sign_a || sign_b);
  // Bitwise equal, or both zeros of any sign
  assign equal_o     = (operand_a_i == operand_b_i) || (info_a_o.is_zero && info_b_o.is_zero);

  // Only legal encodings reach execute
  always_comb begin
    a_legal_func : assert final (valid_i !== 1'b1 || func_o != FN_ILLEGAL)
      else $error("illegal op/rm combination accepted");
  end

endmodule

`default_nettype wire

// File: design/fp_classify.sv
`default_nettype none

module fp_classify (
  input  fp_noncomp_pkg::fp_word_t operand_i,
  output fp_noncomp_pkg::fp_info_t info_o
);

  import fp_noncomp_pkg::*;

  logic [EXP_BITS-1:0] exponent;
  logic [MAN_BITS-1:0] mantissa;
  logic                exp_all_zero;
  logic                exp_all_ones;
  logic                man_zero;

  // Field split, sign is not needed here
  assign exponent = operand_i[FP_WIDTH-2 -: EXP_BITS];
  assign mantissa = operand_i[MAN_BITS-1:0];

  assign exp_all_zero = (exponent == '0);
  assign exp_all_ones = (exponent == '1);
  assign man_zero     = (mantissa == '0);

  // Exponent range picks the class, mantissa splits the edges
  assign info_o.is_normal    = !exp_all_zero && !exp_all_ones;
  assign info_o.is_subnormal = exp_all_zero && !man_zero;
  assign info_o.is_zero      = exp_all_zero && man_zero;
  assign info_o.is_inf       = exp_all_ones && man_zero;
  assign info_o.is_nan       = exp_all_ones && !man_zero;
  // Quiet bit clear means signalling
  assign info_o.is_snan      = info_o.is_nan && !mantissa[MAN_BITS-1];

  // Exactly one class for any known operand
  always_comb begin
    a_one_class : assert final (
      $isunknown(operand_i) ||
      $onehot({info_o.is_normal, info_o.is_subnormal, info_o.is_zero,
               info_o.is_inf, info_o.is_nan})
    ) else $error("operand fell into zero or several classes");
  end

endmodule

`default_nettype wire

// File: design/fp_pipe_reg.sv
`default_nettype none

module fp_pipe_reg #(
  parameter int unsigned DataWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  // Upstream side
  input  logic                 valid_i,
  output logic                 ready_o,
  input  logic [DataWidth-1:0] data_i,
  // Downstream side
  output logic                 valid_o,
  input  logic                 ready_i,
  output logic [DataWidth-1:0] data_o
);

  logic                 valid_q;
  logic [DataWidth-1:0] data_q;

  // Accept when empty or when the item leaves this cycle
  assign ready_o = ready_i | ~valid_q;

  // ------------------------------------------------
  // Valid bit
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      // Drop whatever is held
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // ------------------------------------------------
  // Payload
  // ------------------------------------------------
  // Load only on a real transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  // Stalled item must stay put until downstream takes it
  a_hold_when_stalled : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (valid_o && !ready_i && !flush_i) |=> (valid_o && $stable(data_o))
  ) else $error("pipe stage dropped or changed a stalled item");

endmodule

`default_nettype wire

// File: design/fp_noncomp_pkg.sv
`default_nettype none

package fp_noncomp_pkg;

  // ------------------------------------------------
  // Format
  // ------------------------------------------------
  // Binary32 only
  localparam int unsigned FP_WIDTH = 32;
  localparam int unsigned EXP_BITS = 8;
  localparam int unsigned MAN_BITS = 23;

  // One operand or result word
  typedef logic [FP_WIDTH-1:0] fp_word_t;

  // Positive sign, exponent all ones, only the quiet bit set
  localparam fp_word_t CANON_QNAN = {1'b0, {EXP_BITS{1'b1}}, 1'b1, {(MAN_BITS-1){1'b0}}};

  // ------------------------------------------------
  // Operations
  // ------------------------------------------------
  // Operation group as seen on the input port
  typedef enum logic [1:0] {
    OP_SGNJ     = 2'd0,
    OP_MINMAX   = 2'd1,
    OP_CMP      = 2'd2,
    OP_CLASSIFY = 2'd3
  } fp_op_e;

  // Rounding-mode field, reused to select the sub-operation
  typedef enum logic [2:0] {
    RM_RNE = 3'b000,
    RM_RTZ = 3'b001,
    RM_RDN = 3'b010,
    RM_RUP = 3'b011
  } fp_rm_e;

  // Decoded function code
  typedef enum logic [3:0] {
    FN_SGNJ    = 4'd0,
    FN_SGNJN   = 4'd1,
    FN_SGNJX   = 4'd2,
    FN_MIN     = 4'd3,
    FN_MAX     = 4'd4,
    FN_LE      = 4'd5,
    FN_LT      = 4'd6,
    FN_EQ      = 4'd7,
    FN_CLASS   = 4'd8,
    FN_ILLEGAL = 4'd15
  } fp_func_e;

  // ------------------------------------------------
  // Results
  // ------------------------------------------------
  // Flags NV DZ OF UF NX, high to low
  typedef logic [4:0] fp_status_t;
  localparam int unsigned NV_BIT = 4;

  // One-hot class mask, RISC-V fclass bit order
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } fp_classmask_e;

  // Per-operand classification flags
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_snan;
  } fp_info_t;

  // Stage payloads
  // Input: operand a, operand b, op, rm, op_mod
  localparam int unsigned PIPE_IN_BITS = 2 * FP_WIDTH + $bits(fp_op_e) + $bits(fp_rm_e) + 1;
  // Output: result, status, class mask, is_class
  localparam int unsigned PIPE_OUT_BITS = FP_WIDTH + $bits(fp_status_t)
                                        + $bits(fp_classmask_e) + 1;

endpackage

`default_nettype wire
